// ==== logic/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] reg_sel_t;

    // First fetch address after reset and register clearing
    localparam word_t reset_pc = 32'h0000_0000;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_op = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;

    // funct3 values for the ALU and branch groups
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

endpackage

// ==== logic/ifetch.sv ====
module ifetch import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  word_t  redirect_pc,
    input  logic   decode_stall,
    input  instr_t imem_data,
    output logic   imem_en,
    output word_t  imem_addr,
    output logic   fetch_valid,
    output instr_t instr,
    output word_t  instr_addr
);

    word_t  fetch_addr;
    logic   pending;
    word_t  pending_addr;
    logic   hold_valid;
    instr_t hold_instr;
    word_t  hold_addr;
    logic   accept;
    logic   issue;

    // A word is visible either straight from the memory or from the holding register,
    // never from both at once
    assign fetch_valid = pending || hold_valid;
    assign instr = hold_valid ? hold_instr : imem_data;
    assign instr_addr = hold_valid ? hold_addr : pending_addr;
    assign accept = fetch_valid && !decode_stall;

    // Only fetch when the visible slot is empty or leaving this cycle
    assign issue = !flush && (!fetch_valid || accept);
    assign imem_en = issue;
    assign imem_addr = fetch_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            hold_valid <= 1'b0;
            fetch_addr <= reset_pc;
        end else if (flush) begin
            pending <= 1'b0;
            hold_valid <= 1'b0;
            fetch_addr <= redirect_pc;
        end else begin
            pending <= issue;
            if (issue) begin
                fetch_addr <= fetch_addr + 32'd4;
            end
            if (pending && !accept) begin
                hold_valid <= 1'b1;
            end else if (accept) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // The returned word only needs parking when decode does not take it right away
    always_ff @(posedge clk) begin
        if (issue) begin
            pending_addr <= fetch_addr;
        end
        if (pending && !accept) begin
            hold_instr <= imem_data;
            hold_addr <= pending_addr;
        end
    end

endmodule

// ==== logic/decode.sv ====
module decode import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     fetch_valid,
    input  instr_t   instr,
    input  word_t    instr_addr,
    output logic     decode_stall,
    output reg_sel_t rs1_sel,
    output reg_sel_t rs2_sel,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  logic     exec_valid,
    input  logic     exec_wen,
    input  reg_sel_t exec_rd,
    input  word_t    exec_result,
    input  logic     wb_wen,
    input  reg_sel_t wb_rd,
    input  word_t    wb_data,
    output logic     dec_valid,
    output alu_op_t  dec_op,
    output word_t    dec_a,
    output word_t    dec_b,
    output reg_sel_t dec_rd,
    output logic     dec_wen,
    output logic     dec_is_branch,
    output logic     dec_branch_ne,
    output logic     dec_is_jal,
    output word_t    dec_cmp_b,
    output word_t    dec_target,
    output word_t    dec_addr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_sel_t   rd;
    word_t      i_imm, u_imm, b_imm, j_imm;
    word_t      rs1_fwd, rs2_fwd;
    logic       uses_rs1, uses_rs2;
    alu_op_t    nxt_op;
    word_t      nxt_a, nxt_b, nxt_target;
    logic       nxt_wen, nxt_branch, nxt_jal;

    assign opcode = instr[6:0];
    assign rd = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];
    assign funct7 = instr[31:25];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign uses_rs1 = (opcode == op_op) || (opcode == op_imm) || (opcode == op_branch);
    assign uses_rs2 = (opcode == op_op) || (opcode == op_branch);

    // Pick the youngest copy of a source; exec is newer than writeback
    function automatic word_t bypass(reg_sel_t sel, word_t rf_data);
        if (sel != '0 && exec_valid && exec_wen && exec_rd == sel)
            return exec_result;
        if (sel != '0 && wb_wen && wb_rd == sel)
            return wb_data;
        return rf_data;
    endfunction

    always_comb begin
        rs1_fwd = bypass(rs1_sel, rs1_data);
        rs2_fwd = bypass(rs2_sel, rs2_data);
    end

    // The producer sitting in our own output register has no result yet
    assign decode_stall = fetch_valid && dec_valid && dec_wen && dec_rd != '0 &&
                          ((uses_rs1 && rs1_sel == dec_rd) || (uses_rs2 && rs2_sel == dec_rd));

    always_comb begin
        nxt_op = alu_add;
        nxt_a = rs1_fwd;
        nxt_b = rs2_fwd;
        nxt_wen = 1'b0;
        nxt_branch = 1'b0;
        nxt_jal = 1'b0;
        nxt_target = instr_addr + b_imm;
        case (opcode)
            op_op, op_imm: begin
                nxt_wen = 1'b1;
                if (opcode == op_imm)
                    nxt_b = i_imm;
                case (funct3)
                    f3_xor: nxt_op = alu_xor;
                    f3_or: nxt_op = alu_or;
                    f3_and: nxt_op = alu_and;
                    default: nxt_op = (opcode == op_op && funct7 == f7_sub) ? alu_sub : alu_add;
                endcase
            end
            op_lui: begin
                nxt_wen = 1'b1;
                nxt_b = u_imm;
                nxt_op = alu_pass_b;
            end
            op_branch: begin
                nxt_branch = (funct3 == f3_beq) || (funct3 == f3_bne);
            end
            op_jal: begin
                // Link value is produced by the ALU as address plus 4
                nxt_wen = 1'b1;
                nxt_jal = 1'b1;
                nxt_a = instr_addr;
                nxt_b = 32'd4;
                nxt_target = instr_addr + j_imm;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid && !decode_stall;
        end
    end

    always_ff @(posedge clk) begin
        dec_op <= nxt_op;
        dec_a <= nxt_a;
        dec_b <= nxt_b;
        dec_rd <= rd;
        dec_wen <= nxt_wen;
        dec_is_branch <= nxt_branch;
        dec_branch_ne <= (funct3 == f3_bne);
        dec_is_jal <= nxt_jal;
        dec_cmp_b <= rs2_fwd;
        dec_target <= nxt_target;
        dec_addr <= instr_addr;
    end

endmodule

// ==== logic/exec.sv ====
module exec import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     dec_valid,
    input  alu_op_t  dec_op,
    input  word_t    dec_a,
    input  word_t    dec_b,
    input  reg_sel_t dec_rd,
    input  logic     dec_wen,
    input  logic     dec_is_branch,
    input  logic     dec_branch_ne,
    input  logic     dec_is_jal,
    input  word_t    dec_cmp_b,
    input  word_t    dec_target,
    input  word_t    dec_addr,
    output logic     exec_valid,
    output reg_sel_t exec_rd,
    output logic     exec_wen,
    output word_t    exec_result,
    output word_t    exec_next_pc,
    output logic     redirect,
    output word_t    redirect_pc
);

    word_t alu_out;
    word_t seq_pc;
    word_t next_pc;
    logic  taken;
    logic  take_input;

    always_comb begin
        case (dec_op)
            alu_sub: alu_out = dec_a - dec_b;
            alu_and: alu_out = dec_a & dec_b;
            alu_or: alu_out = dec_a | dec_b;
            alu_xor: alu_out = dec_a ^ dec_b;
            alu_pass_b: alu_out = dec_b;
            default: alu_out = dec_a + dec_b;
        endcase
    end

    // BNE is the inverse of the BEQ compare
    assign taken = dec_is_jal || (dec_is_branch && ((dec_a == dec_cmp_b) ^ dec_branch_ne));
    assign seq_pc = dec_addr + 32'd4;
    assign next_pc = taken ? dec_target : seq_pc;

    // Whatever decode holds while a redirect is out is on the wrong path
    assign take_input = dec_valid && !redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid <= 1'b0;
            redirect <= 1'b0;
        end else begin
            exec_valid <= take_input;
            redirect <= take_input && taken && (dec_target != seq_pc);
        end
    end

    always_ff @(posedge clk) begin
        exec_rd <= dec_rd;
        exec_wen <= dec_wen;
        exec_result <= alu_out;
        exec_next_pc <= next_pc;
    end

    assign redirect_pc = exec_next_pc;

endmodule

// ==== logic/writeback.sv ====
module writeback import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     exec_valid,
    input  reg_sel_t exec_rd,
    input  logic     exec_wen,
    input  word_t    exec_result,
    input  word_t    exec_next_pc,
    output logic     wb_wen,
    output reg_sel_t wb_rd,
    output word_t    wb_data,
    output word_t    reg_pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_wen <= 1'b0;
            reg_pc <= reset_pc;
        end else begin
            wb_wen <= exec_valid && exec_wen;
            // Committed PC follows every retired instruction
            if (exec_valid)
                reg_pc <= exec_next_pc;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= exec_rd;
        wb_data <= exec_result;
    end

endmodule

// ==== logic/int_regfile.sv ====
module int_regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     wen,
    input  reg_sel_t wsel,
    input  word_t    wdata,
    input  reg_sel_t read1_sel,
    input  reg_sel_t read2_sel,
    input  reg_sel_t read3_sel,
    output word_t    read1_data,
    output word_t    read2_data,
    output word_t    read3_data
);

    word_t regs [32];

    // x0 is hardwired, so its storage is never looked at
    assign read1_data = (read1_sel == '0) ? '0 : regs[read1_sel];
    assign read2_data = (read2_sel == '0) ? '0 : regs[read2_sel];
    assign read3_data = (read3_sel == '0) ? '0 : regs[read3_sel];

    always_ff @(posedge clk) begin
        if (wen)
            regs[wsel] <= wdata;
    end

endmodule

// ==== logic/core.sv ====
module core import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  instr_t   imem_data,
    input  reg_sel_t reg_read_sel,
    output logic     imem_en,
    output word_t    imem_addr,
    output word_t    reg_read_data,
    output word_t    reg_pc
);

    reg_sel_t clear_sel;
    logic     clearing;

    logic     fetch_valid, decode_stall;
    instr_t   instr;
    word_t    instr_addr;

    reg_sel_t rs1_sel, rs2_sel;
    word_t    rs1_data, rs2_data;

    logic     dec_valid, dec_wen, dec_is_branch, dec_branch_ne, dec_is_jal;
    alu_op_t  dec_op;
    word_t    dec_a, dec_b, dec_cmp_b, dec_target, dec_addr;
    reg_sel_t dec_rd;

    logic     exec_valid, exec_wen, redirect;
    reg_sel_t exec_rd;
    word_t    exec_result, exec_next_pc, redirect_pc;

    logic     wb_wen;
    reg_sel_t wb_rd;
    word_t    wb_data;

    // Walk x31 down to x1 after reset, writing zero into each
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_sel <= 5'd31;
            clearing <= 1'b1;
        end else if (clearing) begin
            clear_sel <= clear_sel - 5'd1;
            if (clear_sel == 5'd1)
                clearing <= 1'b0;
        end
    end

    // Fetch sits in flush while clearing and comes out of it pointing at reset_pc
    ifetch ifetch_i (
        .clk, .rst,
        .flush(clearing || redirect),
        .redirect_pc(clearing ? reset_pc : redirect_pc),
        .decode_stall, .imem_data, .imem_en, .imem_addr,
        .fetch_valid, .instr, .instr_addr
    );

    decode decode_i (
        .clk, .rst,
        .flush(redirect),
        .fetch_valid, .instr, .instr_addr, .decode_stall,
        .rs1_sel, .rs2_sel, .rs1_data, .rs2_data,
        .exec_valid, .exec_wen, .exec_rd, .exec_result,
        .wb_wen, .wb_rd, .wb_data,
        .dec_valid, .dec_op, .dec_a, .dec_b, .dec_rd, .dec_wen,
        .dec_is_branch, .dec_branch_ne, .dec_is_jal,
        .dec_cmp_b, .dec_target, .dec_addr
    );

    exec exec_i (
        .clk, .rst,
        .dec_valid, .dec_op, .dec_a, .dec_b, .dec_rd, .dec_wen,
        .dec_is_branch, .dec_branch_ne, .dec_is_jal,
        .dec_cmp_b, .dec_target, .dec_addr,
        .exec_valid, .exec_rd, .exec_wen, .exec_result, .exec_next_pc,
        .redirect, .redirect_pc
    );

    writeback writeback_i (
        .clk, .rst,
        .exec_valid, .exec_rd, .exec_wen, .exec_result, .exec_next_pc,
        .wb_wen, .wb_rd, .wb_data, .reg_pc
    );

    int_regfile regs_i (
        .clk,
        .wen(clearing || wb_wen),
        .wsel(clearing ? clear_sel : wb_rd),
        .wdata(clearing ? '0 : wb_data),
        .read1_sel(rs1_sel),
        .read2_sel(rs2_sel),
        .read3_sel(reg_read_sel),
        .read1_data(rs1_data),
        .read2_data(rs2_data),
        .read3_data(reg_read_data)
    );

endmodule

// ==== verif/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Right shifting Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic word_t lfsr_next(input word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit handed out
function automatic word_t take_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
endtask

// Registers come from x0 to x7 only, so back-to-back hazards are frequent
task automatic generate_program();
    logic [3:0] kind;
    logic [2:0] f3;
    reg_sel_t   rd;
    reg_sel_t   rs1;
    reg_sel_t   rs2;
    word_t      off;
    instr_t     ins;
    for (int w = 0; w < halt_word; w++) begin
        kind = 4'(take_bits(4) % 13);
        rd = 5'(take_bits(3));
        rs1 = 5'(take_bits(3));
        rs2 = 5'(take_bits(3));
        // Forward offsets land at most on the first halt word
        off = ((take_bits(5) % word_t'(halt_word - w)) + 1) << 2;
        case (kind)
            4'd2, 4'd6: f3 = 3'b111;
            4'd3, 4'd7: f3 = 3'b110;
            4'd4, 4'd8: f3 = 3'b100;
            4'd11: f3 = 3'b001;
            default: f3 = 3'b000;
        endcase
        if (kind <= 4'd4) begin
            ins = {(kind == 4'd1) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, op_op};
        end else if (kind <= 4'd8) begin
            ins = {12'(take_bits(12)), rs1, f3, rd, op_imm};
        end else if (kind == 4'd9) begin
            ins = {20'(take_bits(20)), rd, op_lui};
        end else if (kind <= 4'd11) begin
            ins = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
        end else begin
            ins = {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
        end
        imem[w[5:0]] = ins;
    end
    // Three self-jumps at the end keep the fetch that runs ahead of the halt inside the image
    for (int w = halt_word; w < n_words; w++) begin
        imem[w[5:0]] = {25'b0, op_jal};
    end
endtask

`endif

// ==== verif/core_tb.sv ====
module core_tb import core_pkg::*; ();

    localparam int n_words = 64;
    localparam int halt_word = 61;
    localparam int n_programs = 20;
    localparam int clear_cycles = 31;
    localparam int reset_cycles = 10;
    localparam int halt_limit = clear_cycles + n_words * 10;
    localparam int watchdog_time =
        (n_words * n_programs * 10 + (n_programs + 1) * clear_cycles) * 10;
    localparam word_t last_addr = word_t'((n_words - 1) * 4);

    logic     clk;
    logic     rst;
    instr_t   imem_data = '0;
    reg_sel_t reg_read_sel;
    logic     imem_en;
    word_t    imem_addr;
    word_t    reg_read_data;
    word_t    reg_pc;

    instr_t imem [n_words];
    word_t  model_regs [32];
    word_t  halt_addr;
    word_t  lfsr = 32'hf945_3610;
    int     errors = 0;
    int     fetch_errors = 0;
    logic   fetch_en_q;
    word_t  fetch_addr_q;

    `include "tb_program.svh"

    core dut_i (
        .clk,
        .rst,
        .imem_data,
        .reg_read_sel,
        .imem_en,
        .imem_addr,
        .reg_read_data,
        .reg_pc
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction memory with one cycle of read latency
    // The request is taken at the falling edge, where the DUT outputs are settled
    always begin
        @(negedge clk);
        fetch_en_q = imem_en;
        fetch_addr_q = imem_addr;
        if (rst === 1'b0 && fetch_en_q === 1'b1 &&
            (fetch_addr_q > last_addr || fetch_addr_q[1:0] != 2'b00)) begin
            fetch_errors++;
            $display("Fetch from address %h lies outside the %0d-word program",
                     fetch_addr_q, n_words);
        end
        @(posedge clk);
        #1;
        if (fetch_en_q === 1'b1) begin
            imem_data = imem[fetch_addr_q[7:2]];
        end
    end

    initial begin
        #(watchdog_time);
        $display("Timeout after %0d time units, the run did not complete", watchdog_time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ISA-level reference that runs the program in order until the halt loop
    task automatic run_model();
        word_t      pc;
        instr_t     ins;
        logic [6:0] opc;
        logic [2:0] f3;
        reg_sel_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm;
        logic       halted;
        for (int r = 0; r < 32; r++) begin
            model_regs[r[4:0]] = '0;
        end
        pc = reset_pc;
        halted = 1'b0;
        for (int step = 0; step < n_words && !halted; step++) begin
            ins = imem[pc[7:2]];
            opc = ins[6:0];
            rd = ins[11:7];
            f3 = ins[14:12];
            a = model_regs[ins[19:15]];
            b = model_regs[ins[24:20]];
            case (opc)
                op_op, op_imm: begin
                    if (opc == op_imm) begin
                        b = {{20{ins[31]}}, ins[31:20]};
                    end
                    case (f3)
                        3'b100: model_regs[rd] = a ^ b;
                        3'b110: model_regs[rd] = a | b;
                        3'b111: model_regs[rd] = a & b;
                        default: model_regs[rd] = (opc == op_op && ins[30]) ? a - b : a + b;
                    endcase
                    pc = pc + 32'd4;
                end
                op_lui: begin
                    model_regs[rd] = {ins[31:12], 12'b0};
                    pc = pc + 32'd4;
                end
                op_branch: begin
                    imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    pc = ((a == b) != f3[0]) ? pc + imm : pc + 32'd4;
                end
                op_jal: begin
                    imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                    // A jump to itself is where the program stops
                    if (imm == '0) begin
                        halted = 1'b1;
                    end else begin
                        model_regs[rd] = pc + 32'd4;
                        pc = pc + imm;
                    end
                end
                default: halted = 1'b1;
            endcase
            model_regs[0] = '0;
        end
        halt_addr = pc;
    endtask

    task automatic release_reset(input string tag);
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
        check_value({tag, " reset pc"}, reset_pc, reg_pc);
    endtask

    task automatic wait_for_halt(input int prog);
        int cycles;
        cycles = 0;
        while (reg_pc !== halt_addr && cycles < halt_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (reg_pc !== halt_addr) begin
            errors++;
            $display("Program %0d did not reach its halt address %h within %0d cycles",
                     prog, halt_addr, halt_limit);
        end
        // The last write is still one stage away from the register file
        repeat (4) @(posedge clk);
    endtask

    task automatic compare_registers(input string tag);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1 reg_read_sel = r[4:0];
            @(negedge clk);
            check_value($sformatf("%s x%0d", tag, r), model_regs[r[4:0]], reg_read_data);
        end
    endtask

    initial begin
        rst = 1'b1;
        reg_read_sel = '0;
        // Idle image of self-jumps so nothing but the clearing touches the registers
        for (int w = 0; w < n_words; w++) begin
            imem[w[5:0]] = {25'b0, op_jal};
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r[4:0]] = '0;
        end
        release_reset("power-on");
        repeat (clear_cycles + 8) @(posedge clk);
        compare_registers("after reset");

        for (int p = 0; p < n_programs; p++) begin
            @(posedge clk);
            #1 rst = 1'b1;
            generate_program();
            run_model();
            release_reset($sformatf("program %0d", p));
            wait_for_halt(p);
            compare_registers($sformatf("program %0d", p));
        end

        $display("Errors: %0d value mismatches, %0d fetch range violations",
                 errors, fetch_errors);
        if (errors == 0 && fetch_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verif
logic/core_pkg.sv
logic/ifetch.sv
logic/decode.sv
logic/exec.sv
logic/writeback.sv
logic/int_regfile.sv
logic/core.sv
verif/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= core_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for a failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
